// File: logic/ttlBridgePkg.sv
package ttlBridgePkg;

  // Bus and master widths
  localparam int BUS_ADDR_W = 16;
  localparam int BUS_DATA_W = 8;
  localparam int MST_ADDR_W = 32;
  localparam int MST_DATA_W = 32;

  typedef logic [BUS_ADDR_W-1:0] busAddrT;
  typedef logic [BUS_DATA_W-1:0] busDataT;
  typedef logic [MST_ADDR_W-1:0] mstAddrT;
  typedef logic [MST_DATA_W-1:0] mstDataT;

  // Bit 0 cycle active, bit 1 read, bit 2 write
  typedef logic [2:0] busCtrlT;

  // Bit 0 address, bit 1 read data, bit 2 write data
  typedef logic [2:0] intrT;

  typedef logic [2:0] regIdxT;

  // Synchronized view of the TTL pins with active high strobes
  typedef struct packed {
    logic    chipSel;
    logic    readStb;
    logic    writeStb;
    busAddrT address;
    busDataT data;
  } ttlCycleT;

  typedef struct packed {
    logic    req;
    logic    write;
    mstAddrT addr;
    mstDataT wrData;
  } mstReqT;

  typedef struct packed {
    logic    cmplt;
    mstDataT rdData;
  } mstRspT;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    regIdxT  adr;
    mstDataT datW;
  } wbReqT;

  typedef struct packed {
    logic    ack;
    mstDataT datR;
  } wbRspT;

  // Register file to cycle FSM
  typedef struct packed {
    logic    enable;
    mstAddrT base;
    intrT    intrEn;
    intrT    intrPending;
    busAddrT busAddress;
    busDataT busData;
  } bridgeCtlT;

  // Cycle FSM to register file
  typedef struct packed {
    busCtrlT busCtrl;
    logic    loadAddr;
    logic    loadData;
    busAddrT capAddr;
    busDataT capData;
    intrT    raise;
  } bridgeEvtT;

  // Wishbone word offsets
  localparam regIdxT REG_CONTROL     = 3'd0;
  localparam regIdxT REG_STATUS      = 3'd1;
  localparam regIdxT REG_BASE        = 3'd2;
  localparam regIdxT REG_BUS_ADDR    = 3'd3;
  localparam regIdxT REG_BUS_DATA    = 3'd4;
  localparam regIdxT REG_INTR_EN     = 3'd5;
  localparam regIdxT REG_INTR_STATUS = 3'd6;

endpackage

// File: logic/ttlBusSync.sv
`timescale 1ns/1ps

module ttlBusSync (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  nChipEnable,
  input  logic                  nOutputEnable,
  input  logic                  nWriteEnable,
  input  ttlBridgePkg::busAddrT address,
  input  ttlBridgePkg::busDataT dataIn,
  output ttlBridgePkg::ttlCycleT cycle
);

  // Strobes are inverted on entry, so bit 2 is chip select, bit 1 read, bit 0 write
  logic [2:0] strbMeta;
  logic [2:0] strbSync;

  ttlBridgePkg::busAddrT addrMeta;
  ttlBridgePkg::busAddrT addrSync;
  ttlBridgePkg::busDataT dataMeta;
  ttlBridgePkg::busDataT dataSync;

  // Two flop synchronizer on the strobes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      strbMeta <= 3'b000;
      strbSync <= 3'b000;
    end else begin
      strbMeta <= {~nChipEnable, ~nOutputEnable, ~nWriteEnable};
      strbSync <= strbMeta;
    end
  end

  // Address and data follow the same two stage path so they line up with the strobes
  always_ff @(posedge clk) begin
    addrMeta <= address;
    addrSync <= addrMeta;
    dataMeta <= dataIn;
    dataSync <= dataMeta;
  end

  // Pack the cycle descriptor
  always_comb begin
    cycle.chipSel  = strbSync[2];
    cycle.readStb  = strbSync[1];
    cycle.writeStb = strbSync[0];
    cycle.address  = addrSync;
    cycle.data     = dataSync;
  end

endmodule

// File: logic/ttlCycleFsm.sv
`timescale 1ns/1ps

module ttlCycleFsm (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ttlBridgePkg::ttlCycleT  cycle,
  input  ttlBridgePkg::bridgeCtlT ctl,
  output ttlBridgePkg::bridgeEvtT evt,
  output ttlBridgePkg::mstReqT    mstReq,
  input  ttlBridgePkg::mstRspT    mstRsp,
  output ttlBridgePkg::busDataT   dataOut,
  output logic                    dataOe,
  output logic                    nWait
);

  typedef enum logic [3:0] {
    Idle,
    AddrCapture,
    AddrIntrWait,
    MapAddress,
    Decode,
    MstRead,
    ReadIntrWait,
    DriveRead,
    WriteCapture,
    WriteIntrWait,
    MstWrite,
    WaitRelease
  } stateT;

  stateT state;

  ttlBridgePkg::busCtrlT busCtrl;
  ttlBridgePkg::busAddrT addrQ;
  ttlBridgePkg::mstAddrT mstAddrQ;
  ttlBridgePkg::busDataT dataQ;
  ttlBridgePkg::busDataT rdByte;
  ttlBridgePkg::mstReqT  mstReqQ;

  // Only the low byte of a master read goes back to the TTL bus
  assign rdByte = mstRsp.rdData[ttlBridgePkg::BUS_DATA_W-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= Idle;
      busCtrl     <= '0;
      mstReqQ.req <= 1'b0;
    end else begin
      case (state)
        Idle: begin
          if (ctl.enable && cycle.chipSel) begin
            busCtrl <= 3'b001;
            state   <= AddrCapture;
          end
        end

        AddrCapture: begin
          addrQ <= cycle.address;
          state <= ctl.intrEn[0] ? AddrIntrWait : MapAddress;
        end

        // Software may rewrite the address before it clears the status bit
        AddrIntrWait: begin
          if (!ctl.intrPending[0]) begin
            addrQ <= ctl.busAddress;
            state <= MapAddress;
          end
        end

        MapAddress: begin
          mstAddrQ <= ctl.base + ttlBridgePkg::mstAddrT'(addrQ);
          state    <= Decode;
        end

        // Abort if the processor lets go of chip select before any strobe
        Decode: begin
          if (!cycle.chipSel) begin
            busCtrl <= '0;
            state   <= Idle;
          end else if (cycle.readStb) begin
            busCtrl[1]     <= 1'b1;
            mstReqQ.req    <= 1'b1;
            mstReqQ.write  <= 1'b0;
            mstReqQ.addr   <= mstAddrQ;
            mstReqQ.wrData <= '0;
            state          <= MstRead;
          end else if (cycle.writeStb) begin
            busCtrl[2] <= 1'b1;
            state      <= WriteCapture;
          end
        end

        MstRead: begin
          if (mstRsp.cmplt) begin
            mstReqQ.req <= 1'b0;
            dataQ       <= rdByte;
            state       <= ctl.intrEn[1] ? ReadIntrWait : DriveRead;
          end
        end

        ReadIntrWait: begin
          if (!ctl.intrPending[1]) begin
            dataQ <= ctl.busData;
            state <= DriveRead;
          end
        end

        DriveRead: begin
          if (!(cycle.chipSel && cycle.readStb)) begin
            state <= WaitRelease;
          end
        end

        WriteCapture: begin
          if (ctl.intrEn[2]) begin
            state <= WriteIntrWait;
          end else begin
            mstReqQ.req    <= 1'b1;
            mstReqQ.write  <= 1'b1;
            mstReqQ.addr   <= mstAddrQ;
            mstReqQ.wrData <= ttlBridgePkg::mstDataT'(cycle.data);
            state          <= MstWrite;
          end
        end

        // Write data comes from the register that software may have overridden
        WriteIntrWait: begin
          if (!ctl.intrPending[2]) begin
            mstReqQ.req    <= 1'b1;
            mstReqQ.write  <= 1'b1;
            mstReqQ.addr   <= mstAddrQ;
            mstReqQ.wrData <= ttlBridgePkg::mstDataT'(ctl.busData);
            state          <= MstWrite;
          end
        end

        MstWrite: begin
          if (mstRsp.cmplt) begin
            mstReqQ.req <= 1'b0;
            state       <= WaitRelease;
          end
        end

        WaitRelease: begin
          if (!cycle.chipSel) begin
            busCtrl <= '0;
            state   <= Idle;
          end
        end

        default: state <= Idle;
      endcase
    end
  end

  // Load and raise pulses last exactly one cycle each
  always_comb begin
    evt          = '0;
    evt.busCtrl  = busCtrl;
    evt.loadAddr = (state == AddrCapture);
    evt.capAddr  = cycle.address;
    evt.loadData = (state == WriteCapture) || ((state == MstRead) && mstRsp.cmplt);
    evt.capData  = (state == MstRead) ? rdByte : cycle.data;
    evt.raise[0] = (state == AddrCapture) && ctl.intrEn[0];
    evt.raise[1] = (state == MstRead) && mstRsp.cmplt && ctl.intrEn[1];
    evt.raise[2] = (state == WriteCapture) && ctl.intrEn[2];
  end

  assign mstReq  = mstReqQ;
  assign dataOut = dataQ;
  assign dataOe  = (state == DriveRead) && cycle.chipSel && cycle.readStb;

  // Processor is held for the whole access except while data is driven or released
  assign nWait = (state == Idle) || (state == DriveRead) || (state == WaitRelease);

endmodule

// File: logic/ttlRegFile.sv
`timescale 1ns/1ps

module ttlRegFile (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ttlBridgePkg::wbReqT     wbReq,
  output ttlBridgePkg::wbRspT     wbRsp,
  input  ttlBridgePkg::bridgeEvtT evt,
  output ttlBridgePkg::bridgeCtlT ctl,
  output logic                    irq
);

  logic                  enable;
  ttlBridgePkg::mstAddrT base;
  ttlBridgePkg::busAddrT busAddr;
  ttlBridgePkg::busDataT busData;
  ttlBridgePkg::intrT    intrEn;
  ttlBridgePkg::intrT    intrStat;
  ttlBridgePkg::intrT    intrClr;

  logic                  ack;
  logic                  wbAccess;
  logic                  wbWrite;
  ttlBridgePkg::mstDataT datR;
  ttlBridgePkg::mstDataT readMux;

  // A new access starts when cyc and stb are seen and no ack is out
  assign wbAccess = wbReq.cyc && wbReq.stb && !ack;
  assign wbWrite  = wbAccess && wbReq.we;

  // Write one to clear
  assign intrClr = (wbWrite && (wbReq.adr == ttlBridgePkg::REG_INTR_STATUS)) ?
                   ttlBridgePkg::intrT'(wbReq.datW) : '0;

  always_comb begin
    case (wbReq.adr)
      ttlBridgePkg::REG_CONTROL:     readMux = ttlBridgePkg::mstDataT'(enable);
      ttlBridgePkg::REG_STATUS:      readMux = ttlBridgePkg::mstDataT'({evt.busCtrl, enable});
      ttlBridgePkg::REG_BASE:        readMux = base;
      ttlBridgePkg::REG_BUS_ADDR:    readMux = ttlBridgePkg::mstDataT'(busAddr);
      ttlBridgePkg::REG_BUS_DATA:    readMux = ttlBridgePkg::mstDataT'(busData);
      ttlBridgePkg::REG_INTR_EN:     readMux = ttlBridgePkg::mstDataT'(intrEn);
      ttlBridgePkg::REG_INTR_STATUS: readMux = ttlBridgePkg::mstDataT'(intrStat);
      default:                       readMux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack      <= 1'b0;
      enable   <= 1'b0;
      base     <= '0;
      busAddr  <= '0;
      busData  <= '0;
      intrEn   <= '0;
      intrStat <= '0;
    end else begin
      ack <= wbAccess;

      if (wbWrite) begin
        case (wbReq.adr)
          ttlBridgePkg::REG_CONTROL:  enable  <= wbReq.datW[0];
          ttlBridgePkg::REG_BASE:     base    <= wbReq.datW;
          ttlBridgePkg::REG_BUS_ADDR: busAddr <= ttlBridgePkg::busAddrT'(wbReq.datW);
          ttlBridgePkg::REG_BUS_DATA: busData <= ttlBridgePkg::busDataT'(wbReq.datW);
          ttlBridgePkg::REG_INTR_EN:  intrEn  <= ttlBridgePkg::intrT'(wbReq.datW);
          default: ;
        endcase
      end

      // Captures from the bus cycle take priority over a software write
      if (evt.loadAddr) begin
        busAddr <= evt.capAddr;
      end
      if (evt.loadData) begin
        busData <= evt.capData;
      end

      // A raise in the same cycle as a clear wins
      intrStat <= (intrStat & ~intrClr) | evt.raise;
    end
  end

  // Read data is registered with the ack
  always_ff @(posedge clk) begin
    if (wbAccess) begin
      datR <= readMux;
    end
  end

  assign wbRsp.ack  = ack;
  assign wbRsp.datR = datR;

  assign irq = |(intrStat & intrEn);

  always_comb begin
    ctl.enable      = enable;
    ctl.base        = base;
    ctl.intrEn      = intrEn;
    ctl.intrPending = intrStat;
    ctl.busAddress  = busAddr;
    ctl.busData     = busData;
  end

endmodule

// File: logic/ttlMemoryBridge.sv
`timescale 1ns/1ps

module ttlMemoryBridge (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  nChipEnable,
  input  logic                  nOutputEnable,
  input  logic                  nWriteEnable,
  input  ttlBridgePkg::busAddrT address,
  input  ttlBridgePkg::busDataT dataIn,
  output ttlBridgePkg::busDataT dataOut,
  output logic                  dataOe,
  output logic                  nWait,
  output ttlBridgePkg::mstReqT  mstReq,
  input  ttlBridgePkg::mstRspT  mstRsp,
  input  ttlBridgePkg::wbReqT   wbReq,
  output ttlBridgePkg::wbRspT   wbRsp,
  output logic                  irq
);

  ttlBridgePkg::ttlCycleT  cycle;
  ttlBridgePkg::bridgeCtlT ctl;
  ttlBridgePkg::bridgeEvtT evt;

  ttlBusSync uSync (
    .clk           (clk),
    .rst_n         (rst_n),
    .nChipEnable   (nChipEnable),
    .nOutputEnable (nOutputEnable),
    .nWriteEnable  (nWriteEnable),
    .address       (address),
    .dataIn        (dataIn),
    .cycle         (cycle)
  );

  ttlCycleFsm uFsm (
    .clk     (clk),
    .rst_n   (rst_n),
    .cycle   (cycle),
    .ctl     (ctl),
    .evt     (evt),
    .mstReq  (mstReq),
    .mstRsp  (mstRsp),
    .dataOut (dataOut),
    .dataOe  (dataOe),
    .nWait   (nWait)
  );

  ttlRegFile uRegs (
    .clk   (clk),
    .rst_n (rst_n),
    .wbReq (wbReq),
    .wbRsp (wbRsp),
    .evt   (evt),
    .ctl   (ctl),
    .irq   (irq)
  );

endmodule

// File: testbench/ttlMemoryBridge_assert.sv
`timescale 1ns/1ps

module ttlMemoryBridgeAssert (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 nOutputEnable,
  input logic                 dataOe,
  input logic                 nWait,
  input ttlBridgePkg::mstReqT mstReq,
  input ttlBridgePkg::mstRspT mstRsp,
  input ttlBridgePkg::wbReqT  wbReq,
  input ttlBridgePkg::wbRspT  wbRsp
);

  // Request and its fields hold until cmplt
  reqStable: assert property (@(posedge clk) disable iff (!rst_n)
    mstReq.req && !mstRsp.cmplt |=> $stable(mstReq))
    else $error("master request changed before cmplt");

  // Pins reach the FSM through two flops, so dataOe follows nOutputEnable two cycles late
  oeFollowsStrobe: assert property (@(posedge clk) disable iff (!rst_n)
    dataOe |-> !$past(nOutputEnable, 2))
    else $error("dataOe high while nOutputEnable was high");

  resetState: assert property (@(posedge clk)
    $rose(rst_n) |-> nWait && !mstReq.req)
    else $error("nWait or req wrong right after reset");

  ackAfterCyc: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(wbReq.cyc) |-> !wbRsp.ack)
    else $error("Wishbone ack still high after cyc fell");

  ackNeedsCyc: assert property (@(posedge clk) disable iff (!rst_n)
    wbRsp.ack |-> wbReq.cyc)
    else $error("Wishbone ack without cyc");

endmodule

bind ttlMemoryBridge ttlMemoryBridgeAssert uAssert (
  .clk           (clk),
  .rst_n         (rst_n),
  .nOutputEnable (nOutputEnable),
  .dataOe        (dataOe),
  .nWait         (nWait),
  .mstReq        (mstReq),
  .mstRsp        (mstRsp),
  .wbReq         (wbReq),
  .wbRsp         (wbRsp)
);

// File: testbench/ttlMemoryBridgeTb.sv
`timescale 1ns/1ps

module ttlMemoryBridgeTb;

  localparam int NUM_RANDOM = 8;
  localparam int STEP_LIMIT = 200;
  // Each bus access and Wishbone operation is allowed 40 clocks
  localparam int WATCHDOG_CYCLES = (2 * NUM_RANDOM + 4 + 24) * 40;

  typedef struct packed {
    logic                  write;
    ttlBridgePkg::mstAddrT addr;
    ttlBridgePkg::mstDataT data;
  } xferT;

  logic clk;
  logic rst_n;
  logic nChipEnable;
  logic nOutputEnable;
  logic nWriteEnable;
  logic dataOe;
  logic nWait;
  logic irq;
  ttlBridgePkg::busAddrT address;
  ttlBridgePkg::busDataT dataIn;
  ttlBridgePkg::busDataT dataOut;
  ttlBridgePkg::mstReqT  mstReq;
  ttlBridgePkg::mstRspT  mstRsp;
  ttlBridgePkg::wbReqT   wbReq;
  ttlBridgePkg::wbRspT   wbRsp;

  logic [31:0]           lfsr;
  ttlBridgePkg::mstDataT mem [ttlBridgePkg::mstAddrT];
  xferT                  expQ[$];
  xferT                  obsQ[$];
  ttlBridgePkg::mstAddrT base;
  int                    errors;
  int                    checks;
  int                    testErrBase;
  int                    testCount;

  ttlMemoryBridge dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .nChipEnable   (nChipEnable),
    .nOutputEnable (nOutputEnable),
    .nWriteEnable  (nWriteEnable),
    .address       (address),
    .dataIn        (dataIn),
    .dataOut       (dataOut),
    .dataOe        (dataOe),
    .nWait         (nWait),
    .mstReq        (mstReq),
    .mstRsp        (mstRsp),
    .wbReq         (wbReq),
    .wbRsp         (wbRsp),
    .irq           (irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = nextLfsr(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Untouched memory holds a pattern built from the whole address
  function automatic ttlBridgePkg::mstDataT modelWord(input ttlBridgePkg::mstAddrT a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return a ^ {a[7:0], a[31:8]} ^ 32'h6b3d_1c97;
  endfunction

  function automatic ttlBridgePkg::mstAddrT expectedMasterAddress(
    input ttlBridgePkg::mstAddrT b, input ttlBridgePkg::busAddrT a);
    return b + {16'h0000, a};
  endfunction

  task automatic failure(input string msg);
    errors++;
    $display("%0t: %s", $time, msg);
  endtask

  task automatic checkData(input string name, input ttlBridgePkg::busDataT got,
                           input ttlBridgePkg::busDataT want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic checkAddr(input string name, input ttlBridgePkg::mstAddrT got,
                           input ttlBridgePkg::mstAddrT want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic checkWord(input string name, input ttlBridgePkg::mstDataT got,
                           input ttlBridgePkg::mstDataT want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic endTest(input string name);
    testCount++;
    $display("Test %0d %s: %0d errors", testCount, name, errors - testErrBase);
    testErrBase = errors;
  endtask

  task automatic wbCycle(input logic we, input ttlBridgePkg::regIdxT idx,
                         input ttlBridgePkg::mstDataT val, output ttlBridgePkg::mstDataT rdVal);
    int n;
    @(posedge clk);
    wbReq <= {1'b1, 1'b1, we, idx, val};
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!wbRsp.ack && n < STEP_LIMIT);
    if (!wbRsp.ack) begin
      failure("Wishbone ack never came");
    end
    rdVal = wbRsp.datR;
    wbReq <= '0;
  endtask

  task automatic wbWrite(input ttlBridgePkg::regIdxT idx, input ttlBridgePkg::mstDataT val);
    ttlBridgePkg::mstDataT unused;
    wbCycle(1'b1, idx, val, unused);
  endtask

  task automatic wbRead(input ttlBridgePkg::regIdxT idx, output ttlBridgePkg::mstDataT val);
    wbCycle(1'b0, idx, '0, val);
  endtask

  task automatic waitIrq();
    int n;
    n = 0;
    while (!irq && n < STEP_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (!irq) begin
      failure("irq never rose");
    end
  endtask

  // Processor strobes and waits for the hold and its release before it lets go
  task automatic busAccess(input logic write, input ttlBridgePkg::busAddrT a,
                           input ttlBridgePkg::busDataT d, output ttlBridgePkg::busDataT got);
    int n;
    @(posedge clk);
    address       <= a;
    dataIn        <= d;
    nChipEnable   <= 1'b0;
    nOutputEnable <= write;
    nWriteEnable  <= !write;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (nWait && n < STEP_LIMIT);
    if (nWait) begin
      failure("nWait never went low for the access");
    end
    n = 0;
    while (!nWait && n < STEP_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (!nWait) begin
      failure("nWait never returned high");
    end
    got = dataOut;
    if (!write && !dataOe) begin
      failure("dataOe was low when read data was due");
    end
    nChipEnable   <= 1'b1;
    nOutputEnable <= 1'b1;
    nWriteEnable  <= 1'b1;
    repeat (6) @(posedge clk);
  endtask

  // Memory responder with a random 0 to 7 cycle latency
  initial begin : responder
    int delay;
    forever begin
      @(posedge clk);
      if (rst_n && mstReq.req) begin
        delay = takeBits(3);
        repeat (delay) @(posedge clk);
        obsQ.push_back({mstReq.write, mstReq.addr, mstReq.wrData});
        if (mstReq.write) begin
          mem[mstReq.addr] = mstReq.wrData;
        end
        mstRsp <= {1'b1, modelWord(mstReq.addr)};
        @(posedge clk);
        mstRsp <= '0;
      end
    end
  end

  initial begin : comparer
    xferT got;
    xferT want;
    forever begin
      @(posedge clk);
      while (obsQ.size() > 0) begin
        got = obsQ.pop_front();
        if (expQ.size() == 0) begin
          failure($sformatf("Unexpected master request to address %h", got.addr));
        end else begin
          want = expQ.pop_front();
          if (got.write !== want.write) begin
            failure("Master request went in the wrong direction");
          end
          checkAddr("mstReq.addr", got.addr, want.addr);
          if (want.write) begin
            checkWord("mstReq.wrData", got.data, want.data);
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin : main
    ttlBridgePkg::busAddrT a;
    ttlBridgePkg::busAddrT a2;
    ttlBridgePkg::busDataT d;
    ttlBridgePkg::busDataT d2;
    ttlBridgePkg::busDataT got;
    ttlBridgePkg::mstDataT rd;
    ttlBridgePkg::mstDataT rd2;
    int lowCycles;
    rst_n         = 1'b0;
    nChipEnable   = 1'b1;
    nOutputEnable = 1'b1;
    nWriteEnable  = 1'b1;
    address       = '0;
    dataIn        = '0;
    mstRsp        = '0;
    wbReq         = '0;
    lfsr          = 32'hd9cf;
    errors        = 0;
    checks        = 0;
    testErrBase   = 0;
    testCount     = 0;
    base          = 32'h0001_f800;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    wbRead(ttlBridgePkg::REG_INTR_STATUS, rd);
    checkWord("intr status", rd, 32'd0);
    wbWrite(ttlBridgePkg::REG_CONTROL, 32'd1);
    wbWrite(ttlBridgePkg::REG_BASE, base);
    wbWrite(ttlBridgePkg::REG_INTR_EN, 32'd7);
    wbRead(ttlBridgePkg::REG_CONTROL, rd);
    checkWord("control", rd, 32'd1);
    wbRead(ttlBridgePkg::REG_BASE, rd);
    checkWord("base", rd, base);
    wbRead(ttlBridgePkg::REG_INTR_EN, rd);
    checkWord("intr enable", rd, 32'd7);
    wbWrite(ttlBridgePkg::REG_INTR_EN, 32'd0);
    endTest("register access");

    repeat (NUM_RANDOM) begin
      a  = ttlBridgePkg::busAddrT'(takeBits(16));
      rd = modelWord(expectedMasterAddress(base, a));
      expQ.push_back({1'b0, expectedMasterAddress(base, a), 32'h0});
      busAccess(1'b0, a, 8'h00, got);
      checkData("dataOut", got, rd[7:0]);
    end
    endTest("plain reads");

    repeat (NUM_RANDOM) begin
      a = ttlBridgePkg::busAddrT'(takeBits(16));
      d = ttlBridgePkg::busDataT'(takeBits(8));
      expQ.push_back({1'b1, expectedMasterAddress(base, a), {24'h0, d}});
      busAccess(1'b1, a, d, got);
      checkWord("model memory", modelWord(expectedMasterAddress(base, a)), {24'h0, d});
    end
    endTest("plain writes");

    // Software replaces the captured address while the bridge holds
    wbWrite(ttlBridgePkg::REG_INTR_EN, 32'd1);
    a  = ttlBridgePkg::busAddrT'(takeBits(16));
    a2 = ttlBridgePkg::busAddrT'(takeBits(16));
    rd = modelWord(expectedMasterAddress(base, a2));
    expQ.push_back({1'b0, expectedMasterAddress(base, a2), 32'h0});
    fork
      busAccess(1'b0, a, 8'h00, got);
      begin
        waitIrq();
        wbRead(ttlBridgePkg::REG_BUS_ADDR, rd2);
        checkAddr("bus address register", rd2, {16'h0000, a});
        wbWrite(ttlBridgePkg::REG_BUS_ADDR, {16'h0000, a2});
        wbWrite(ttlBridgePkg::REG_INTR_STATUS, 32'd1);
      end
    join
    checkData("dataOut", got, rd[7:0]);
    endTest("address interrupt");

    wbWrite(ttlBridgePkg::REG_INTR_EN, 32'd2);
    a  = ttlBridgePkg::busAddrT'(takeBits(16));
    d  = ttlBridgePkg::busDataT'(takeBits(8));
    rd = modelWord(expectedMasterAddress(base, a));
    expQ.push_back({1'b0, expectedMasterAddress(base, a), 32'h0});
    fork
      busAccess(1'b0, a, 8'h00, got);
      begin
        waitIrq();
        wbRead(ttlBridgePkg::REG_BUS_DATA, rd2);
        checkWord("bus data register", rd2, {24'h0, rd[7:0]});
        wbWrite(ttlBridgePkg::REG_BUS_DATA, {24'h0, d});
        wbWrite(ttlBridgePkg::REG_INTR_STATUS, 32'd2);
      end
    join
    checkData("dataOut", got, d);

    wbWrite(ttlBridgePkg::REG_INTR_EN, 32'd4);
    a  = ttlBridgePkg::busAddrT'(takeBits(16));
    d  = ttlBridgePkg::busDataT'(takeBits(8));
    d2 = ttlBridgePkg::busDataT'(takeBits(8));
    expQ.push_back({1'b1, expectedMasterAddress(base, a), {24'h0, d2}});
    fork
      busAccess(1'b1, a, d, got);
      begin
        waitIrq();
        wbRead(ttlBridgePkg::REG_BUS_DATA, rd2);
        checkWord("bus data register", rd2, {24'h0, d});
        wbWrite(ttlBridgePkg::REG_BUS_DATA, {24'h0, d2});
        wbWrite(ttlBridgePkg::REG_INTR_STATUS, 32'd4);
      end
    join
    checkWord("model memory", modelWord(expectedMasterAddress(base, a)), {24'h0, d2});
    wbWrite(ttlBridgePkg::REG_INTR_EN, 32'd0);
    endTest("data interrupts");

    // Any request here shows up in the comparer as unexpected
    wbWrite(ttlBridgePkg::REG_CONTROL, 32'd0);
    @(posedge clk);
    address       <= ttlBridgePkg::busAddrT'(takeBits(16));
    nChipEnable   <= 1'b0;
    nOutputEnable <= 1'b0;
    lowCycles = 0;
    repeat (50) begin
      @(posedge clk);
      if (!nWait) begin
        lowCycles++;
      end
    end
    if (lowCycles != 0) begin
      failure("nWait went low while the bridge was disabled");
    end
    nChipEnable   <= 1'b1;
    nOutputEnable <= 1'b1;
    repeat (6) @(posedge clk);
    endTest("disabled bridge");

    if (expQ.size() != 0) begin
      failure($sformatf("%0d expected master requests never arrived", expQ.size()));
    end
    $display("Tests %0d, checks %0d, errors %0d", testCount, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: ttlMemoryBridge.f
logic/ttlBridgePkg.sv
logic/ttlBusSync.sv
logic/ttlCycleFsm.sv
logic/ttlRegFile.sv
logic/ttlMemoryBridge.sv
testbench/ttlMemoryBridge_assert.sv
testbench/ttlMemoryBridgeTb.sv

// File: Makefile
SIM := obj_dir/VttlMemoryBridgeTb

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All checks passed" sim.log

$(SIM): ttlMemoryBridge.f $(wildcard logic/*.sv testbench/*.sv)
	verilator --binary --timing --assert --top-module ttlMemoryBridgeTb \
		-f ttlMemoryBridge.f -o VttlMemoryBridgeTb

clean:
	rm -rf obj_dir sim.log
